// File: design/datapathPkg.sv
`default_nettype none

package datapathPkg;

    localparam int wordWidth = 32; // Bus and register width
    localparam int numRegs = 16;
    localparam int constWidth = 19; // Immediate field of the IR

    // Same codes as the instruction opcode field
    typedef enum logic [4:0] {
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opShr  = 5'b00101,
        opShra = 5'b00110,
        opShl  = 5'b00111,
        opRor  = 5'b01000,
        opRol  = 5'b01001,
        opAnd  = 5'b01010,
        opOr   = 5'b01011,
        opMul  = 5'b01111,
        opDiv  = 5'b10000,
        opNeg  = 5'b10001,
        opNot  = 5'b10010,
        opNop  = 5'b11010
    } aluOp;

    typedef logic [numRegs-1:0] regMask; // One bit per general register

    // One control word per clock
    typedef struct packed {
        regMask regIn;
        regMask regOut;
        logic   hiIn;
        logic   hiOut;
        logic   loIn;
        logic   loOut;
        logic   pcIn;
        logic   pcOut;
        logic   irIn;
        logic   marIn;
        logic   mdrIn;
        logic   mdrOut;
        logic   yIn;
        logic   zIn;
        logic   zHighOut;
        logic   zLowOut;
        logic   incPc;    // Z takes bus plus 1
        logic   read;     // MDR takes memory data
        logic   constOut;
        logic   inPortOut;
        aluOp   aluOp;
    } controlWord;

    // Register form and immediate form of the same IR word
    typedef union packed {
        struct packed {
            logic [4:0]  opcode;
            logic [3:0]  ra;
            logic [3:0]  rb;
            logic [3:0]  rc;
            logic [14:0] spare;
        } regForm;
        struct packed {
            logic [4:0]            opcode;
            logic [3:0]            ra;
            logic [3:0]            rb;
            logic [constWidth-1:0] constant;
        } immForm;
    } instrWord;

    typedef enum logic [3:0] {
        srcReg,
        srcHi,
        srcLo,
        srcZHigh,
        srcZLow,
        srcPc,
        srcMdr,
        srcInPort,
        srcConst,
        srcNone
    } busSource;

endpackage

`default_nettype wire

// File: design/registerFile.sv
`timescale 1ns/100ps
`default_nettype none

module registerFile (
    input  logic                             clock,
    input  logic                             reset,
    input  logic [datapathPkg::wordWidth-1:0] busData,
    input  datapathPkg::regMask              regIn,
    input  datapathPkg::regMask              regOut,
    input  logic                             hiIn,
    input  logic                             loIn,
    output logic [datapathPkg::wordWidth-1:0] gpData,
    output logic [datapathPkg::wordWidth-1:0] hiData,
    output logic [datapathPkg::wordWidth-1:0] loData
);
    import datapathPkg::*;

    logic [wordWidth-1:0] gpRegs [numRegs];

    // Several registers may load the same bus value at once
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < numRegs; i++) begin
                gpRegs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < numRegs; i++) begin
                if (regIn[i]) begin
                    gpRegs[i] <= busData;
                end
            end
        end
    end

    // Wide result halves
    always_ff @(posedge clock) begin
        if (reset) begin
            hiData <= '0;
            loData <= '0;
        end else begin
            if (hiIn) begin
                hiData <= busData;
            end
            if (loIn) begin
                loData <= busData;
            end
        end
    end

    // Walk down so the lowest set bit wins, as on the bus
    always_comb begin
        gpData = '0;
        for (int i = numRegs - 1; i >= 0; i--) begin
            if (regOut[i]) begin
                gpData = gpRegs[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: design/memoryInterface.sv
`timescale 1ns/100ps
`default_nettype none

module memoryInterface (
    input  logic                             clock,
    input  logic                             reset,
    input  logic [datapathPkg::wordWidth-1:0] busData,
    input  logic [datapathPkg::wordWidth-1:0] memDataIn,
    input  logic                             read,
    input  logic                             mdrIn,
    input  logic                             marIn,
    output logic [datapathPkg::wordWidth-1:0] mdrData,
    output logic [datapathPkg::wordWidth-1:0] marOut
);
    import datapathPkg::*;

    logic [wordWidth-1:0] mdrNext;

    // Memory data has precedence over the bus
    assign mdrNext = read ? memDataIn : busData;

    always_ff @(posedge clock) begin
        if (reset) begin
            mdrData <= '0;
        end else if (mdrIn) begin
            mdrData <= mdrNext;
        end
    end

    // Address goes straight out to memory
    always_ff @(posedge clock) begin
        if (reset) begin
            marOut <= '0;
        end else if (marIn) begin
            marOut <= busData;
        end
    end

endmodule

`default_nettype wire

// File: design/instructionUnit.sv
`timescale 1ns/100ps
`default_nettype none

module instructionUnit (
    input  logic                             clock,
    input  logic                             reset,
    input  logic [datapathPkg::wordWidth-1:0] busData,
    input  logic [datapathPkg::wordWidth-1:0] inPortData,
    input  logic                             pcIn,
    input  logic                             irIn,
    output logic [datapathPkg::wordWidth-1:0] pcData,
    output logic [datapathPkg::wordWidth-1:0] constData,
    output logic [datapathPkg::wordWidth-1:0] inPortReg,
    output datapathPkg::instrWord            irData
);
    import datapathPkg::*;

    logic signBit;

    always_ff @(posedge clock) begin
        if (reset) begin
            pcData <= '0;
            irData <= '0;
        end else begin
            if (pcIn) begin
                pcData <= busData;
            end
            if (irIn) begin
                irData <= busData; // Stored as the raw word
            end
        end
    end

    // Input port has no load enable
    always_ff @(posedge clock) begin
        if (reset) begin
            inPortReg <= '0;
        end else begin
            inPortReg <= inPortData;
        end
    end

    // Immediate view of the IR, sign extended to a full word
    assign signBit = irData.immForm.constant[constWidth-1];
    assign constData = {{(wordWidth - constWidth){signBit}}, irData.immForm.constant};

endmodule

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  logic [datapathPkg::wordWidth-1:0]   opA,
    input  logic [datapathPkg::wordWidth-1:0]   opB,
    input  datapathPkg::aluOp                  op,
    output logic [2*datapathPkg::wordWidth-1:0] result
);
    import datapathPkg::*;

    logic [4:0] shamt; // Low 5 bits of opB
    logic signed [wordWidth-1:0] signedA;
    logic signed [wordWidth-1:0] signedB;
    logic signed [2*wordWidth-1:0] product;
    logic [2*wordWidth-1:0] doubled;
    logic [2*wordWidth-1:0] rorWide;
    logic [2*wordWidth-1:0] rolWide;
    logic [wordWidth-1:0] quotient;
    logic [wordWidth-1:0] remainder;
    logic [wordWidth-1:0] lowWord;

    assign shamt = opB[4:0];
    assign signedA = opA;
    assign signedB = opB;

    // Full signed product, operands extend to 64 bits
    assign product = signedA * signedB;

    // Rotates taken from two copies of opA side by side
    assign doubled = {opA, opA};
    assign rorWide = doubled >> shamt;
    assign rolWide = doubled << shamt;

    // Signed divide
    always_comb begin
        if (opB == '0) begin
            quotient = '1;     // Divide by zero marker
            remainder = opA;
        end else begin
            quotient = signedA / signedB;
            remainder = signedA % signedB;
        end
    end

    // Single word results
    always_comb begin
        case (op)
            opAdd:   lowWord = opA + opB;
            opSub:   lowWord = opA - opB;
            opAnd:   lowWord = opA & opB;
            opOr:    lowWord = opA | opB;
            opShr:   lowWord = opA >> shamt;
            opShra:  lowWord = signedA >>> shamt;
            opShl:   lowWord = opA << shamt;
            opRor:   lowWord = rorWide[wordWidth-1:0];
            opRol:   lowWord = rolWide[2*wordWidth-1:wordWidth];
            // Unary ops take the bus operand, Y is ignored
            opNeg:   lowWord = -opB;
            opNot:   lowWord = ~opB;
            default: lowWord = '0; // nop
        endcase
    end

    always_comb begin
        case (op)
            opMul:   result = product;
            opDiv:   result = {remainder, quotient}; // Remainder in high word
            default: result = {{wordWidth{1'b0}}, lowWord};
        endcase
    end

endmodule

`default_nettype wire

// File: design/aluStage.sv
`timescale 1ns/100ps
`default_nettype none

module aluStage (
    input  logic                               clock,
    input  logic                               reset,
    input  logic [datapathPkg::wordWidth-1:0]   busData,
    input  logic                               yIn,
    input  logic                               zIn,
    input  logic                               incPc,
    input  datapathPkg::aluOp                  aluOp,
    output logic [2*datapathPkg::wordWidth-1:0] zData
);
    import datapathPkg::*;

    logic [wordWidth-1:0] yReg;
    logic [2*wordWidth-1:0] aluResult;
    logic [2*wordWidth-1:0] zNext;

    // First operand latch
    always_ff @(posedge clock) begin
        if (reset) begin
            yReg <= '0;
        end else if (yIn) begin
            yReg <= busData;
        end
    end

    alu i_alu (
        .opA    (yReg),
        .opB    (busData),
        .op     (aluOp),
        .result (aluResult)
    );

    // PC increment bypasses the ALU
    assign zNext = incPc ? {{wordWidth{1'b0}}, busData + 32'd1} : aluResult;

    always_ff @(posedge clock) begin
        if (reset) begin
            zData <= '0;
        end else if (zIn) begin
            zData <= zNext;
        end
    end

endmodule

`default_nettype wire

// File: design/busMultiplexer.sv
`timescale 1ns/100ps
`default_nettype none

module busMultiplexer (
    input  datapathPkg::regMask   regOut,
    input  logic                  hiOut,
    input  logic                  loOut,
    input  logic                  zHighOut,
    input  logic                  zLowOut,
    input  logic                  pcOut,
    input  logic                  mdrOut,
    input  logic                  inPortOut,
    input  logic                  constOut,
    output datapathPkg::busSource source
);
    import datapathPkg::*;

    // Fixed priority, at most one driver ever reaches the bus
    always_comb begin
        if (mdrOut) begin
            source = srcMdr;
        end else if (pcOut) begin
            source = srcPc;
        end else if (zLowOut) begin
            source = srcZLow;
        end else if (zHighOut) begin
            source = srcZHigh;
        end else if (hiOut) begin
            source = srcHi;
        end else if (loOut) begin
            source = srcLo;
        end else if (inPortOut) begin
            source = srcInPort;
        end else if (constOut) begin
            source = srcConst;
        end else if (|regOut) begin
            source = srcReg; // Register file picks the lowest index
        end else begin
            source = srcNone;
        end
    end

endmodule

`default_nettype wire

// File: design/datapath.sv
`timescale 1ns/100ps
`default_nettype none

module datapath (
    input  logic                             clock,
    input  logic                             reset,
    input  datapathPkg::controlWord          ctrl,
    input  logic [datapathPkg::wordWidth-1:0] memDataIn,
    input  logic [datapathPkg::wordWidth-1:0] inPortData,
    output logic [datapathPkg::wordWidth-1:0] busData,
    output logic [datapathPkg::wordWidth-1:0] marOut
);
    import datapathPkg::*;

    logic [wordWidth-1:0] gpData;
    logic [wordWidth-1:0] hiData;
    logic [wordWidth-1:0] loData;
    logic [wordWidth-1:0] pcData;
    logic [wordWidth-1:0] mdrData;
    logic [wordWidth-1:0] inPortReg;
    logic [wordWidth-1:0] constData;
    logic [2*wordWidth-1:0] zData;
    busSource source;

    busMultiplexer i_busMultiplexer (
        .regOut    (ctrl.regOut),
        .hiOut     (ctrl.hiOut),
        .loOut     (ctrl.loOut),
        .zHighOut  (ctrl.zHighOut),
        .zLowOut   (ctrl.zLowOut),
        .pcOut     (ctrl.pcOut),
        .mdrOut    (ctrl.mdrOut),
        .inPortOut (ctrl.inPortOut),
        .constOut  (ctrl.constOut),
        .source    (source)
    );

    registerFile i_registerFile (
        .clock   (clock),
        .reset   (reset),
        .busData (busData),
        .regIn   (ctrl.regIn),
        .regOut  (ctrl.regOut),
        .hiIn    (ctrl.hiIn),
        .loIn    (ctrl.loIn),
        .gpData  (gpData),
        .hiData  (hiData),
        .loData  (loData)
    );

    memoryInterface i_memoryInterface (
        .clock     (clock),
        .reset     (reset),
        .busData   (busData),
        .memDataIn (memDataIn),
        .read      (ctrl.read),
        .mdrIn     (ctrl.mdrIn),
        .marIn     (ctrl.marIn),
        .mdrData   (mdrData),
        .marOut    (marOut)
    );

    // No decoder in this datapath, IR fields only reach the bus as constData
    instructionUnit i_instructionUnit (
        .clock      (clock),
        .reset      (reset),
        .busData    (busData),
        .inPortData (inPortData),
        .pcIn       (ctrl.pcIn),
        .irIn       (ctrl.irIn),
        .pcData     (pcData),
        .constData  (constData),
        .inPortReg  (inPortReg),
        .irData     ()
    );

    aluStage i_aluStage (
        .clock   (clock),
        .reset   (reset),
        .busData (busData),
        .yIn     (ctrl.yIn),
        .zIn     (ctrl.zIn),
        .incPc   (ctrl.incPc),
        .aluOp   (ctrl.aluOp),
        .zData   (zData)
    );

    // The shared bus
    always_comb begin
        case (source)
            srcReg:    busData = gpData;
            srcHi:     busData = hiData;
            srcLo:     busData = loData;
            srcZHigh:  busData = zData[2*wordWidth-1:wordWidth];
            srcZLow:   busData = zData[wordWidth-1:0];
            srcPc:     busData = pcData;
            srcMdr:    busData = mdrData;
            srcInPort: busData = inPortReg;
            srcConst:  busData = constData;
            default:   busData = '0; // Nobody driving
        endcase
    end

endmodule

`default_nettype wire

// File: dv/datapathTb.sv
`timescale 1ns/100ps
`default_nettype none

module datapathTb;
    import datapathPkg::*;

    localparam int resetCycles = 4;

    // One row of the stimulus table
    typedef struct packed {
        controlWord           ctrl;
        logic [wordWidth-1:0] mem;
        logic [wordWidth-1:0] port;
        logic [wordWidth-1:0] expBus;
        logic                 checkBus;
        logic [wordWidth-1:0] expMar;
        logic                 checkMar;
        logic [7:0]           testId;
    } stepEntry;

    logic clock;
    logic reset;
    controlWord ctrl;
    logic [wordWidth-1:0] memDataIn;
    logic [wordWidth-1:0] inPortData;
    logic [wordWidth-1:0] busData;
    logic [wordWidth-1:0] marOut;

    stepEntry steps[$];
    string testNames[$];
    int seed = 32'hbe2b;
    int errorCount = 0;
    int checkCount = 0;
    bit tableReady = 0;
    logic [wordWidth-1:0] nextMem = '0;  // Data columns for the next rows
    logic [wordWidth-1:0] nextPort = '0;
    logic [wordWidth-1:0] pcValue;       // Tracked state for later tests
    logic [wordWidth-1:0] portValue;
    logic [wordWidth-1:0] constValue;

    datapath i_dut (
        .clock      (clock),
        .reset      (reset),
        .ctrl       (ctrl),
        .memDataIn  (memDataIn),
        .inPortData (inPortData),
        .busData    (busData),
        .marOut     (marOut)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;

    function automatic logic [wordWidth-1:0] randWord();
        return $random(seed);
    endfunction

    task automatic compareValue(input logic [wordWidth-1:0] actual,
                                input logic [wordWidth-1:0] expected, input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Error at %0t ns: %s expected %h, got %h", $time, what, expected, actual);
        end
    endtask

    task automatic startTest(input string name);
        testNames.push_back(name);
    endtask

    task automatic pushStep(input controlWord c, input logic [wordWidth-1:0] expBus,
                            input logic checkBus, input logic [wordWidth-1:0] expMar,
                            input logic checkMar);
        stepEntry s;
        s.ctrl = c;
        s.mem = nextMem;
        s.port = nextPort;
        s.expBus = expBus;
        s.checkBus = checkBus;
        s.expMar = expMar;
        s.checkMar = checkMar;
        s.testId = testNames.size() - 1;
        steps.push_back(s);
    endtask

    task automatic addCheck(input controlWord c, input logic [wordWidth-1:0] value);
        pushStep(c, value, 1'b1, '0, 1'b0);
    endtask

    // Memory read straight into MDR with the bus idle
    task automatic loadMdr(input logic [wordWidth-1:0] value);
        controlWord c;
        c = '0;
        c.read = 1'b1;
        c.mdrIn = 1'b1;
        nextMem = value;
        addCheck(c, '0);
    endtask

    task automatic loadReg(input int idx, input logic [wordWidth-1:0] value);
        controlWord c;
        loadMdr(value);
        c = '0;
        c.mdrOut = 1'b1;
        c.regIn[idx] = 1'b1;
        addCheck(c, value);
        c = '0;
        c.regOut[idx] = 1'b1;
        addCheck(c, value);
    endtask

    // R4 into Y, R5 on the bus, Z halves through LO and HI
    task automatic aluCheck(input aluOp op, input logic [wordWidth-1:0] a,
                            input logic [wordWidth-1:0] b, input logic [wordWidth-1:0] expLow,
                            input logic [wordWidth-1:0] expHigh);
        controlWord c;
        loadReg(4, a);
        loadReg(5, b);
        c = '0;
        c.regOut[4] = 1'b1;
        c.yIn = 1'b1;
        addCheck(c, a);
        c = '0;
        c.regOut[5] = 1'b1;
        c.zIn = 1'b1;
        c.aluOp = op;
        addCheck(c, b);
        c = '0;
        c.zLowOut = 1'b1;
        c.loIn = 1'b1;
        addCheck(c, expLow);
        c = '0;
        c.zHighOut = 1'b1;
        c.hiIn = 1'b1;
        addCheck(c, expHigh);
        c = '0;
        c.loOut = 1'b1;
        addCheck(c, expLow);
        c = '0;
        c.hiOut = 1'b1;
        addCheck(c, expHigh);
    endtask

    // Builds an instruction in register form and reads it back as a constant
    task automatic irConstant(input logic [3:0] rcField);
        controlWord c;
        instrWord ins;
        logic [wordWidth-1:0] r;
        r = randWord();
        ins.regForm.opcode = opAdd;
        ins.regForm.ra = 4'd1;
        ins.regForm.rb = 4'd2;
        ins.regForm.rc = rcField;
        ins.regForm.spare = r[14:0];
        constValue = {{13{rcField[3]}}, rcField, r[14:0]};
        loadMdr(ins);
        c = '0;
        c.mdrOut = 1'b1;
        c.irIn = 1'b1;
        addCheck(c, ins);
        c = '0;
        c.constOut = 1'b1;
        addCheck(c, constValue);
    endtask

    task automatic buildTable();
        controlWord c;
        logic [wordWidth-1:0] a;
        logic [wordWidth-1:0] b;
        logic [4:0] s;
        longint product;
        int qa;
        int qb;

        startTest("registers clear after reset");
        for (int i = 0; i < numRegs; i++) begin
            c = '0;
            c.regOut[i] = 1'b1;
            addCheck(c, '0);
        end
        c = '0;
        c.hiOut = 1'b1;
        addCheck(c, '0);
        c = '0;
        c.loOut = 1'b1;
        addCheck(c, '0);
        c = '0;
        c.zHighOut = 1'b1;
        addCheck(c, '0);
        c = '0;
        c.zLowOut = 1'b1;
        addCheck(c, '0);
        c = '0;
        c.pcOut = 1'b1;
        addCheck(c, '0);
        c = '0;
        c.mdrOut = 1'b1;
        addCheck(c, '0);
        c = '0;
        c.constOut = 1'b1;
        addCheck(c, '0);
        c = '0;
        c.inPortOut = 1'b1;
        addCheck(c, '0);
        addCheck('0, '0); // No driver

        startTest("memory loads into registers");
        loadReg(2, randWord());
        loadReg(7, randWord());
        loadReg(11, randWord());
        loadReg(15, randWord());

        startTest("pc increment and shr sequence");
        loadReg(2, 32'd5);
        loadReg(3, 32'd1);
        pcValue = randWord();
        loadMdr(pcValue);
        c = '0;
        c.mdrOut = 1'b1;
        c.pcIn = 1'b1;
        addCheck(c, pcValue);
        c = '0;
        c.pcOut = 1'b1;
        c.incPc = 1'b1;
        c.zIn = 1'b1;
        addCheck(c, pcValue);
        c = '0;
        c.zLowOut = 1'b1;
        c.pcIn = 1'b1;
        addCheck(c, pcValue + 1);
        pcValue = pcValue + 1;
        c = '0;
        c.pcOut = 1'b1;
        addCheck(c, pcValue);
        c = '0;
        c.regOut[2] = 1'b1;
        c.yIn = 1'b1;
        addCheck(c, 32'd5);
        c = '0;
        c.regOut[3] = 1'b1;
        c.zIn = 1'b1;
        c.aluOp = opShr;
        addCheck(c, 32'd1);
        c = '0;
        c.zLowOut = 1'b1;
        addCheck(c, 32'd2);

        startTest("shift, rotate and logic ops");
        a = randWord();
        b = randWord();
        s = b[4:0];
        aluCheck(opShl, a, b, a << s, '0);
        aluCheck(opShra, a, b, $signed(a) >>> s, '0);
        aluCheck(opRor, a, b, (a >> s) | (a << (32 - s)), '0);
        aluCheck(opRol, a, b, (a << s) | (a >> (32 - s)), '0);
        aluCheck(opAdd, a, b, a + b, '0);
        aluCheck(opSub, a, b, a - b, '0);
        aluCheck(opAnd, a, b, a & b, '0);
        aluCheck(opOr, a, b, a | b, '0);
        aluCheck(opNeg, a, b, -b, '0);  // Unary ops work on the bus operand
        aluCheck(opNot, a, b, ~b, '0);

        startTest("mul and div through HI and LO");
        a = randWord();
        b = randWord();
        product = $signed(a) * $signed(b);
        aluCheck(opMul, a, b, product[31:0], product[63:32]);
        aluCheck(opMul, -32'sd3, 32'sd7, -32'sd21, '1);
        qa = randWord();
        qb = randWord();
        qb = qb >>> 16; // Small divisor for a real quotient
        if (qb == 0) begin
            qb = 7;
        end
        aluCheck(opDiv, qa, qb, qa / qb, qa % qb);
        aluCheck(opDiv, a, '0, '1, a);

        startTest("constant, input port and mar");
        irConstant(4'b1010);
        irConstant(4'b0110);
        nextPort = randWord();
        portValue = nextPort;
        addCheck('0, '0);
        c = '0;
        c.inPortOut = 1'b1;
        addCheck(c, portValue);
        a = randWord();
        loadReg(6, a);
        c = '0;
        c.regOut[6] = 1'b1;
        c.marIn = 1'b1;
        addCheck(c, a);
        pushStep('0, '0, 1'b1, a, 1'b1);

        startTest("bus priority with two drivers");
        a = randWord();
        b = randWord();
        loadReg(2, a);
        loadReg(3, b);
        c = '0;
        c.regOut[2] = 1'b1;
        c.incPc = 1'b1;
        c.zIn = 1'b1;
        c.mdrIn = 1'b1; // MDR takes the bus while read is low
        addCheck(c, a);
        c = '0;
        c.mdrOut = 1'b1;
        c.pcOut = 1'b1;
        addCheck(c, a);
        c = '0;
        c.pcOut = 1'b1;
        c.zLowOut = 1'b1;
        addCheck(c, pcValue);
        c = '0;
        c.zLowOut = 1'b1;
        c.zHighOut = 1'b1;
        addCheck(c, a + 1);
        c = '0;
        c.zHighOut = 1'b1;
        c.regOut[2] = 1'b1;
        addCheck(c, '0);
        c = '0;
        c.regOut[2] = 1'b1;
        c.hiIn = 1'b1;
        addCheck(c, a);
        c = '0;
        c.regOut[3] = 1'b1;
        c.loIn = 1'b1;
        addCheck(c, b);
        c = '0;
        c.zHighOut = 1'b1;
        c.hiOut = 1'b1;
        addCheck(c, '0);
        c = '0;
        c.hiOut = 1'b1;
        c.loOut = 1'b1;
        addCheck(c, a);
        c = '0;
        c.loOut = 1'b1;
        c.inPortOut = 1'b1;
        addCheck(c, b);
        c = '0;
        c.regOut[2] = 1'b1;
        c.regOut[3] = 1'b1;
        addCheck(c, a);
        c = '0;
        c.inPortOut = 1'b1;
        c.constOut = 1'b1;
        addCheck(c, portValue);
        c = '0;
        c.constOut = 1'b1;
        c.regOut[3] = 1'b1;
        addCheck(c, constValue);
    endtask

    // Each row is driven on the falling edge and sampled just before the rising edge
    task automatic applyTable();
        int lastErrors;
        lastErrors = 0;
        for (int i = 0; i < steps.size(); i++) begin
            @(negedge clock);
            ctrl = steps[i].ctrl;
            memDataIn = steps[i].mem;
            inPortData = steps[i].port;
            #4;
            if (steps[i].checkBus) begin
                compareValue(busData, steps[i].expBus, $sformatf("step %0d busData", i));
            end
            if (steps[i].checkMar) begin
                compareValue(marOut, steps[i].expMar, $sformatf("step %0d marOut", i));
            end
            if (i == steps.size() - 1 || steps[i + 1].testId != steps[i].testId) begin
                $display("Test %0d (%s) done with %0d errors", steps[i].testId,
                         testNames[steps[i].testId], errorCount - lastErrors);
                lastErrors = errorCount;
            end
        end
        @(negedge clock);
        ctrl = '0;
    endtask

    initial begin
        ctrl = '0;
        memDataIn = '0;
        inPortData = '0;
        reset = 1'b1;
        buildTable();
        tableReady = 1'b1;
        repeat (resetCycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        applyTable();
        $display("Summary: %0d tests, %0d checks, %0d errors", testNames.size(), checkCount,
                 errorCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Limit from table length plus reset and margin
    initial begin
        wait (tableReady);
        #((steps.size() + resetCycles + 100) * 10);
        $display("Timeout: the run did not finish within the time allowed for the table");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: datapath.f
design/datapathPkg.sv
design/registerFile.sv
design/memoryInterface.sv
design/instructionUnit.sv
design/alu.sv
design/aluStage.sv
design/busMultiplexer.sv
design/datapath.sv
dv/datapathTb.sv
